// File: list.f
src/ppu_pkg.sv
src/ppu_reg_decode.sv
src/ppu_vram_addr.sv
src/ppu_raster_timer.sv
src/ppu_status.sv
src/ppu_palette_ram.sv
src/ppu_bus_result.sv
src/ppu_regs_top.sv
verif/ppu_regs_assertions.sv
verif/tb_ppu_regs.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_ppu_regs -o sim_ppu_regs
./obj_dir/sim_ppu_regs | tee sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi

// File: src/ppu_bus_result.sv
`timescale 1ns/100ps

module ppu_bus_result (
	input  logic                        clk,
	input  logic                        rst,
	input  ppu_pkg::reg_access_t        access,
	input  logic [ppu_pkg::VADDR_W-1:0] vaddr,
	input  logic [ppu_pkg::DATA_W-1:0]  status_byte,
	input  logic [ppu_pkg::PAL_W-1:0]   pal_data,
	input  logic [ppu_pkg::DATA_W-1:0]  slv_mem_din,
	input  logic [ppu_pkg::DATA_W-1:0]  ppu_mem_din,
	output logic [ppu_pkg::DATA_W-1:0]  slv_mem_dout,
	output logic [ppu_pkg::DATA_W-1:0]  ppu_mem_dout,
	output logic                        ppu_mem_wr_request
);

	logic [ppu_pkg::DATA_W-1:0] rd_buf;  // Delayed data read buffer
	logic [ppu_pkg::DATA_W-1:0] rd_next; // Read data selected this cycle
	logic                       in_page;

	assign in_page = (vaddr[ppu_pkg::VADDR_W-1:8] == ppu_pkg::PAL_PAGE);

	//**************************************************
	//* Read buffer
	//**************************************************
	// Fills from the pre-increment address on palette reads too
	always_ff @(posedge clk)
	begin
		if (rst)
			rd_buf <= 8'hFF;
		else if (access.data_rd)
			rd_buf <= ppu_mem_din;
	end

	// Palette answers directly while everything else comes one read late
	always_comb
	begin
		rd_next = '0;
		if (access.status_rd)
			rd_next = status_byte;
		else if (access.data_rd)
			rd_next = in_page ? {2'b00, pal_data} : rd_buf;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			slv_mem_dout <= '0;
		else
			slv_mem_dout <= rd_next; // Zero outside read results
	end

	//**************************************************
	//* Video memory write port
	//**************************************************
	always_ff @(posedge clk)
	begin
		if (rst)
			ppu_mem_wr_request <= 1'b0;
		else
			ppu_mem_wr_request <= access.data_wr; // One cycle after the access
	end

	always_ff @(posedge clk)
	begin
		if (access.data_wr)
			ppu_mem_dout <= slv_mem_din;
	end

endmodule

// File: src/ppu_palette_ram.sv
`timescale 1ns/100ps

module ppu_palette_ram (
	input  logic                        clk,
	input  ppu_pkg::reg_access_t        access,
	input  logic [ppu_pkg::VADDR_W-1:0] vaddr,
	input  logic [ppu_pkg::DATA_W-1:0]  slv_mem_din,
	input  ppu_pkg::ppu_cfg_t           cfg,
	output logic [ppu_pkg::PAL_W-1:0]   pal_data
);

	logic [ppu_pkg::PAL_W-1:0]     pal_mem [0:(2 ** ppu_pkg::PAL_IDX_W)-1];
	logic [ppu_pkg::PAL_IDX_W-1:0] idx;
	logic                          in_page;
	logic [ppu_pkg::PAL_W-1:0]     raw;

	assign in_page = (vaddr[ppu_pkg::VADDR_W-1:8] == ppu_pkg::PAL_PAGE);

	// Sprite backdrop slots 10/14/18/1C share the background ones
	always_comb
	begin
		if (vaddr[4] && (vaddr[1:0] == 2'b00))
			idx = {1'b0, vaddr[3:0]};
		else
			idx = vaddr[ppu_pkg::PAL_IDX_W-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (access.data_wr && in_page)
			pal_mem[idx] <= slv_mem_din[ppu_pkg::PAL_W-1:0]; // Top two data bits dropped
	end

	assign raw = pal_mem[idx];

	// Greyscale keeps the luma bits only
	assign pal_data = cfg.greyscale ? {raw[5:4], 4'b0} : raw;

endmodule

// File: src/ppu_pkg.sv
package ppu_pkg;

	// CPU register indices as the low address bits of $2000-$2007
	localparam logic [2:0] REG_CTRL   = 3'd0;
	localparam logic [2:0] REG_MASK   = 3'd1;
	localparam logic [2:0] REG_STATUS = 3'd2;
	localparam logic [2:0] REG_ADDR   = 3'd6;
	localparam logic [2:0] REG_DATA   = 3'd7;

	// Field widths
	localparam int REG_IDX_W = 3;  // CPU register select
	localparam int DATA_W    = 8;  // CPU and video memory data lane
	localparam int VADDR_W   = 14; // Video address
	localparam int PAL_W     = 6;  // Palette entry (colour index)
	localparam int PAL_IDX_W = 5;  // 32 palette entries
	localparam int RASTER_W  = 9;  // Dot and line counters

	localparam logic [5:0] PAL_PAGE = 6'h3F; // Upper address bits of palette region

	// Raster geometry at one clock per dot
	localparam int DOTS_PER_LINE   = 341;
	localparam int LINES_PER_FRAME = 262;
	localparam int VBLANK_LINE     = 241; // Vblank starts here
	localparam int PRERENDER_LINE  = 261; // Vblank ends here
	localparam int EVENT_DOT       = 1;   // Dot of both vblank events

	// One-hot register access strobes
	typedef struct packed {
		logic ctrl_wr;
		logic mask_wr;
		logic addr_wr;
		logic data_wr;
		logic status_rd;
		logic data_rd;
	} reg_access_t;

	// Kept control and mask fields
	typedef struct packed {
		logic incr_32;    // Address step 32 instead of 1
		logic nmi_enable; // Vblank interrupt enable
		logic greyscale;  // Palette reads masked to grey
	} ppu_cfg_t;

	typedef struct packed {
		logic vblank_set;
		logic vblank_clr;
	} frame_evt_t;

endpackage

// File: src/ppu_raster_timer.sv
`timescale 1ns/100ps

module ppu_raster_timer (
	input  logic                clk,
	input  logic                rst,
	output ppu_pkg::frame_evt_t evt
);

	logic [ppu_pkg::RASTER_W-1:0] dot;
	logic [ppu_pkg::RASTER_W-1:0] line;
	logic                         line_end;

	assign line_end = (dot == ppu_pkg::RASTER_W'(ppu_pkg::DOTS_PER_LINE - 1));

	always_ff @(posedge clk)
	begin
		if (rst || line_end)
			dot <= '0;
		else
			dot <= dot + 1'b1;
	end

	// Frame starts in the pre-render line after reset
	always_ff @(posedge clk)
	begin
		if (rst)
			line <= ppu_pkg::RASTER_W'(ppu_pkg::PRERENDER_LINE);
		else if (line_end)
		begin
			if (line == ppu_pkg::RASTER_W'(ppu_pkg::LINES_PER_FRAME - 1))
				line <= '0;
			else
				line <= line + 1'b1;
		end
	end

	// Single-cycle events, one each per frame
	always_comb
	begin
		evt.vblank_set = (line == ppu_pkg::RASTER_W'(ppu_pkg::VBLANK_LINE)) &&
			(dot == ppu_pkg::RASTER_W'(ppu_pkg::EVENT_DOT));
		evt.vblank_clr = (line == ppu_pkg::RASTER_W'(ppu_pkg::PRERENDER_LINE)) &&
			(dot == ppu_pkg::RASTER_W'(ppu_pkg::EVENT_DOT));
	end

endmodule

// File: src/ppu_reg_decode.sv
`timescale 1ns/100ps

module ppu_reg_decode (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [ppu_pkg::REG_IDX_W-1:0] slv_mem_addr,
	input  logic                          slv_mem_cs,
	input  logic                          slv_mem_rnw,
	output ppu_pkg::reg_access_t          access
);

	logic cs_q;   // Chip select of the previous cycle
	logic cs_new; // First cycle of an access

	// Only the first cycle of a select counts, so a stretched
	// select still gives one strobe and one side effect
	always_ff @(posedge clk)
	begin
		if (rst)
			cs_q <= 1'b0;
		else
			cs_q <= slv_mem_cs;
	end

	assign cs_new = slv_mem_cs & ~cs_q;

	always_comb
	begin
		access = '0;
		if (cs_new)
		begin
			case (slv_mem_addr)
				ppu_pkg::REG_CTRL:   access.ctrl_wr   = ~slv_mem_rnw;
				ppu_pkg::REG_MASK:   access.mask_wr   = ~slv_mem_rnw;
				ppu_pkg::REG_STATUS: access.status_rd = slv_mem_rnw; // Write is ignored
				ppu_pkg::REG_ADDR:   access.addr_wr   = ~slv_mem_rnw;
				ppu_pkg::REG_DATA:
				begin
					access.data_wr = ~slv_mem_rnw;
					access.data_rd = slv_mem_rnw;
				end
				default: access = '0; // OAM and scroll registers are not kept
			endcase
		end
	end

endmodule

// File: src/ppu_regs_top.sv
`timescale 1ns/100ps

module ppu_regs_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [ppu_pkg::REG_IDX_W-1:0] slv_mem_addr,
	input  logic                          slv_mem_cs,
	input  logic                          slv_mem_rnw,
	input  logic [ppu_pkg::DATA_W-1:0]    slv_mem_din,
	output logic [ppu_pkg::DATA_W-1:0]    slv_mem_dout,
	output logic                          irq,
	input  logic [ppu_pkg::DATA_W-1:0]    ppu_mem_din,
	output logic [ppu_pkg::DATA_W-1:0]    ppu_mem_dout,
	output logic [ppu_pkg::VADDR_W-1:0]   ppu_mem_addr,
	output logic                          ppu_mem_wr_request
);

	ppu_pkg::reg_access_t       access;
	ppu_pkg::ppu_cfg_t          cfg;
	ppu_pkg::frame_evt_t        evt;
	logic [ppu_pkg::DATA_W-1:0] status_byte;
	logic [ppu_pkg::PAL_W-1:0]  pal_data;

	//**************************************************
	//* Decode, then the register units
	//**************************************************
	ppu_reg_decode u_decode (
		.clk          (clk),
		.rst          (rst),
		.slv_mem_addr (slv_mem_addr),
		.slv_mem_cs   (slv_mem_cs),
		.slv_mem_rnw  (slv_mem_rnw),
		.access       (access)
	);

	// Live address goes straight to video memory
	ppu_vram_addr u_vram_addr (
		.clk         (clk),
		.rst         (rst),
		.access      (access),
		.slv_mem_din (slv_mem_din),
		.cfg         (cfg),
		.vaddr       (ppu_mem_addr)
	);

	ppu_raster_timer u_raster (
		.clk (clk),
		.rst (rst),
		.evt (evt)
	);

	ppu_status u_status (
		.clk         (clk),
		.rst         (rst),
		.access      (access),
		.evt         (evt),
		.cfg         (cfg),
		.status_byte (status_byte),
		.irq         (irq)
	);

	ppu_palette_ram u_palette (
		.clk         (clk),
		.access      (access),
		.vaddr       (ppu_mem_addr),
		.slv_mem_din (slv_mem_din),
		.cfg         (cfg),
		.pal_data    (pal_data)
	);

	//**************************************************
	//* Result stage
	//**************************************************
	ppu_bus_result u_result (
		.clk                (clk),
		.rst                (rst),
		.access             (access),
		.vaddr              (ppu_mem_addr),
		.status_byte        (status_byte),
		.pal_data           (pal_data),
		.slv_mem_din        (slv_mem_din),
		.ppu_mem_din        (ppu_mem_din),
		.slv_mem_dout       (slv_mem_dout),
		.ppu_mem_dout       (ppu_mem_dout),
		.ppu_mem_wr_request (ppu_mem_wr_request)
	);

endmodule

// File: src/ppu_status.sv
`timescale 1ns/100ps

module ppu_status (
	input  logic                       clk,
	input  logic                       rst,
	input  ppu_pkg::reg_access_t       access,
	input  ppu_pkg::frame_evt_t        evt,
	input  ppu_pkg::ppu_cfg_t          cfg,
	output logic [ppu_pkg::DATA_W-1:0] status_byte,
	output logic                       irq
);

	logic vblank;

	// Clear wins over set so a read in the set cycle loses the flag
	always_ff @(posedge clk)
	begin
		if (rst || evt.vblank_clr || access.status_rd)
			vblank <= 1'b0;
		else if (evt.vblank_set)
			vblank <= 1'b1;
	end

	// Sprite-0 and overflow bits read as zero
	assign status_byte = {vblank, 7'b0};

	always_ff @(posedge clk)
	begin
		if (rst)
			irq <= 1'b0;
		else
			irq <= vblank & cfg.nmi_enable; // Drops on status read or enable off
	end

endmodule

// File: src/ppu_vram_addr.sv
`timescale 1ns/100ps

module ppu_vram_addr (
	input  logic                        clk,
	input  logic                        rst,
	input  ppu_pkg::reg_access_t        access,
	input  logic [ppu_pkg::DATA_W-1:0]  slv_mem_din,
	output ppu_pkg::ppu_cfg_t           cfg,
	output logic [ppu_pkg::VADDR_W-1:0] vaddr
);

	logic                        second_wr; // First/second write toggle
	logic [5:0]                  addr_hi;   // Temporary high byte without its top bits
	logic [ppu_pkg::VADDR_W-1:0] step;      // Increment after a data access

	//**************************************************
	//* Control and mask fields
	//**************************************************
	always_ff @(posedge clk)
	begin
		if (rst)
			cfg <= '0;
		else
		begin
			if (access.ctrl_wr)
			begin
				cfg.nmi_enable <= slv_mem_din[7]; // CTRL bit 7
				cfg.incr_32    <= slv_mem_din[2]; // CTRL bit 2 steps one row down
			end
			if (access.mask_wr)
				cfg.greyscale <= slv_mem_din[0]; // MASK bit 0
		end
	end

	//**************************************************
	//* Write toggle
	//**************************************************
	always_ff @(posedge clk)
	begin
		if (rst || access.status_rd) // Status read restarts the pair
			second_wr <= 1'b0;
		else if (access.addr_wr)
			second_wr <= ~second_wr;
	end

	// High byte parks here until the second write
	always_ff @(posedge clk)
	begin
		if (access.addr_wr && !second_wr)
			addr_hi <= slv_mem_din[5:0];
	end

	//**************************************************
	//* Live video address
	//**************************************************
	assign step = cfg.incr_32 ? ppu_pkg::VADDR_W'(32) : ppu_pkg::VADDR_W'(1);

	always_ff @(posedge clk)
	begin
		if (rst)
			vaddr <= '0;
		else if (access.addr_wr && second_wr)
			vaddr <= {addr_hi, slv_mem_din}; // Low byte completes the address
		else if (access.data_wr || access.data_rd)
			vaddr <= vaddr + step; // Wraps within 14 bits
	end

endmodule

// File: verif/ppu_regs_assertions.sv
`timescale 1ns/100ps

module ppu_regs_assertions (
	input logic                       clk,
	input logic                       rst,
	input logic                       slv_mem_cs,
	input logic                       slv_mem_rnw,
	input logic [ppu_pkg::DATA_W-1:0] slv_mem_dout,
	input logic                       irq,
	input logic                       ppu_mem_wr_request
);

	// Write strobe never stretches past one cycle
	wr_pulse_single: assert property (@(posedge clk) disable iff (rst)
		ppu_mem_wr_request |=> !ppu_mem_wr_request)
		else $error("video memory write request held for more than one cycle");

	// Read data bus idles at zero
	dout_only_after_read: assert property (@(posedge clk) disable iff (rst)
		(slv_mem_dout != 8'h00) |-> $past(slv_mem_cs && slv_mem_rnw))
		else $error("CPU read data nonzero without a read in the previous cycle");

	irq_low_after_reset: assert property (@(posedge clk)
		$past(rst) |-> !irq)
		else $error("irq high in the cycle after reset");

endmodule

bind ppu_regs_top ppu_regs_assertions u_assertions (
	.clk                (clk),
	.rst                (rst),
	.slv_mem_cs         (slv_mem_cs),
	.slv_mem_rnw        (slv_mem_rnw),
	.slv_mem_dout       (slv_mem_dout),
	.irq                (irq),
	.ppu_mem_wr_request (ppu_mem_wr_request)
);

// File: verif/ppu_testdata.txt
# name op reg data expected, all columns after the name in hex
# op 0 write, 1 read and check, 2 check video address, 3 wait for irq
# a write to reg 7 expects the video address of that write
addr_hi       0 6 21 0000
addr_lo       0 6 08 0000
addr_set      2 0 00 2108
data_wr_1     0 7 a5 2108
data_wr_2     0 7 3c 2109
ctrl_inc32    0 0 04 0000
data_wr_3     0 7 77 210a
addr_step32   2 0 00 212a
ctrl_inc1     0 0 00 0000
rd_addr_hi    0 6 03 0000
rd_addr_lo    0 6 45 0000
rd_first      1 7 00 00ff
rd_second     1 7 00 001c
rd_third      1 7 00 001f
pal_hi_1      0 6 3f 0000
pal_lo_1      0 6 10 0000
pal_wr_3f10   0 7 2a 3f10
pal_hi_2      0 6 3f 0000
pal_lo_2      0 6 04 0000
pal_wr_3f04   0 7 15 3f04
pal_hi_3      0 6 3f 0000
pal_lo_3      0 6 00 0000
pal_rd_3f00   1 7 00 002a
pal_hi_4      0 6 3f 0000
pal_lo_4      0 6 14 0000
pal_rd_3f14   1 7 00 0015
grey_on       0 1 01 0000
pal_hi_5      0 6 3f 0000
pal_lo_5      0 6 00 0000
grey_rd_3f00  1 7 00 0020
pal_hi_6      0 6 3f 0000
pal_lo_6      0 6 14 0000
grey_rd_3f14  1 7 00 0010
grey_off      0 1 00 0000
tgl_first     0 6 12 0000
tgl_status    1 2 00 0000
tgl_hi        0 6 25 0000
tgl_lo        0 6 67 0000
tgl_addr      2 0 00 2567
nmi_on        0 0 80 0000
vbl_wait      3 0 00 0000
vbl_status    1 2 00 0080
vbl_cleared   1 2 00 0000

// File: verif/tb_ppu_regs.sv
`timescale 1ns/100ps

module tb_ppu_regs;

	localparam int CLK_HALF  = 20; // 40 ns period
	localparam int DRIVE_DLY = 2;  // Inputs change this long after the rising edge

	// Vblank comes 82,523 cycles after reset and a full frame takes 89,342
	// Bus steps add a few cycles each and leave wide margin
	localparam int TIMEOUT_CYCLES = 200_000;

	localparam logic [3:0] OP_WRITE  = 4'h0;
	localparam logic [3:0] OP_READ   = 4'h1; // Read and compare
	localparam logic [3:0] OP_ADDR   = 4'h2; // Compare live video address
	localparam logic [3:0] OP_VBLANK = 4'h3; // Poll irq

	logic                          clk;
	logic                          rst;
	logic [ppu_pkg::REG_IDX_W-1:0] slv_mem_addr;
	logic                          slv_mem_cs;
	logic                          slv_mem_rnw;
	logic [ppu_pkg::DATA_W-1:0]    slv_mem_din;
	logic [ppu_pkg::DATA_W-1:0]    slv_mem_dout;
	logic                          irq;
	logic [ppu_pkg::DATA_W-1:0]    ppu_mem_din;
	logic [ppu_pkg::DATA_W-1:0]    ppu_mem_dout;
	logic [ppu_pkg::VADDR_W-1:0]   ppu_mem_addr;
	logic                          ppu_mem_wr_request;

	int   cycles;
	int   pass_count;
	int   fail_count;
	logic step_failed; // Set by any failing check of the current step

	ppu_regs_top u_dut (
		.clk                (clk),
		.rst                (rst),
		.slv_mem_addr       (slv_mem_addr),
		.slv_mem_cs         (slv_mem_cs),
		.slv_mem_rnw        (slv_mem_rnw),
		.slv_mem_din        (slv_mem_din),
		.slv_mem_dout       (slv_mem_dout),
		.irq                (irq),
		.ppu_mem_din        (ppu_mem_din),
		.ppu_mem_dout       (ppu_mem_dout),
		.ppu_mem_addr       (ppu_mem_addr),
		.ppu_mem_wr_request (ppu_mem_wr_request)
	);

	// Video memory model folds every address bit into the byte
	assign ppu_mem_din = ppu_mem_addr[7:0] ^ {2'b00, ppu_mem_addr[13:8]} ^ 8'h5A;

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	//**************************************************
	//* Timeout
	//**************************************************
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	//**************************************************
	//* Bus helpers
	//**************************************************
	// One-cycle select that returns in the cycle after the access
	task automatic bus_access(input logic [2:0] reg_idx, input logic rnw,
		input logic [7:0] data);
		slv_mem_addr = reg_idx;
		slv_mem_rnw  = rnw;
		slv_mem_din  = data;
		slv_mem_cs   = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		slv_mem_cs   = 1'b0; // Result and write pulse visible now
		slv_mem_rnw  = 1'b1;
	endtask

	task automatic check_value(input logic [127:0] name, input logic [15:0] exp_val,
		input logic [15:0] act_val);
		assert (act_val === exp_val)
		else
		begin
			$display("MISMATCH %0s expected %h actual %h", name, exp_val, act_val);
			step_failed = 1'b1;
		end
	endtask

	// Runs one line of the testdata file
	task automatic run_step(input logic [127:0] name, input logic [3:0] op,
		input logic [2:0] reg_idx, input logic [7:0] data, input logic [15:0] exp_val);
		logic [ppu_pkg::VADDR_W-1:0] wr_addr;
		step_failed = 1'b0;
		case (op)
			OP_WRITE:
			begin
				wr_addr = ppu_mem_addr; // Address shown during the access
				bus_access(reg_idx, 1'b0, data);
				if (reg_idx == ppu_pkg::REG_DATA)
				begin
					assert (ppu_mem_wr_request === 1'b1)
					else
					begin
						$display("%0s: no write pulse after the data write", name);
						step_failed = 1'b1;
					end
					check_value(name, {8'h00, data}, {8'h00, ppu_mem_dout});
					check_value(name, exp_val, {2'b00, wr_addr});
				end
			end
			OP_READ:
			begin
				bus_access(reg_idx, 1'b1, 8'h00);
				check_value(name, exp_val, {8'h00, slv_mem_dout});
			end
			OP_ADDR: check_value(name, exp_val, {2'b00, ppu_mem_addr});
			OP_VBLANK:
			begin
				while (irq !== 1'b1) // Timeout guards this loop
				begin
					@(posedge clk);
					#DRIVE_DLY;
				end
			end
			default:
			begin
				$display("%0s: unknown operation code %h in the testdata file", name, op);
				step_failed = 1'b1;
			end
		endcase
		@(posedge clk); // Idle cycle between accesses
		#DRIVE_DLY;
		if (step_failed)
		begin
			fail_count++;
			$display("%0s: FAIL", name);
		end
		else
		begin
			pass_count++;
			$display("%0s: ok", name);
		end
	endtask

	//**************************************************
	//* Main sequence
	//**************************************************
	initial
	begin
		int                fd;
		int                rc;
		int                fields;
		logic [8*96-1:0]   text_line;
		logic [127:0]      name;
		logic [3:0]        op;
		logic [2:0]        reg_idx;
		logic [7:0]        data;
		logic [15:0]       exp_val;
		cycles       = 0;
		pass_count   = 0;
		fail_count   = 0;
		step_failed  = 1'b0;
		rst          = 1'b1;
		slv_mem_addr = '0;
		slv_mem_cs   = 1'b0;
		slv_mem_rnw  = 1'b1;
		slv_mem_din  = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		fd = $fopen("verif/ppu_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verif/ppu_testdata.txt");
			fail_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				text_line = '0;
				rc = $fgets(text_line, fd);
				fields = $sscanf(text_line, "%s %h %h %h %h", name, op, reg_idx, data, exp_val);
				if (rc > 0 && fields == 5) // Comment and blank lines fall through
					run_step(name, op, reg_idx, data, exp_val);
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
